/* build.f */
logic/frv_pkg.sv
logic/frv_fetch_if.sv
logic/frv_fetch.sv
logic/frv_decode.sv
logic/frv_pipe_reg.sv
logic/frv_front.sv
test/frv_clock.sv
test/frv_front_asserts.sv
test/frv_front_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frv_front_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/frv_front_tb.sv */
/*
 * Front end testbench.
 * Random program image with a fault window, random memory stall,
 * dispatch back-pressure and redirects, checked against a reference
 * decoder and the expected pc stream.
 */
`default_nettype none

module frv_front_tb;
    import frv_pkg::*;

    localparam logic [31:0] MEM_BASE   = 32'h8000_0000;    // Reset pc and image start
    localparam int          MEM_WORDS  = 256;
    localparam logic [31:0] ERR_LO     = MEM_BASE + 32'h180; // Fault window
    localparam logic [31:0] ERR_HI     = MEM_BASE + 32'h1c0;
    localparam int          N_DELIVER  = 1500;
    localparam int          IDLE_LIMIT = 100;               // Cycles without a transfer
    localparam int          CF_LIMIT   = 100;               // Cycles a redirect may wait
    localparam int          SETTLE     = 10;                // Quarter period after driving

    logic        g_clk;
    logic        g_resetn;
    logic        i_cf_req;
    logic [31:0] i_cf_target;
    logic        o_cf_ack;
    logic        o_imem_cen;
    logic [31:0] o_imem_addr;
    logic        i_imem_stall;
    logic        i_imem_error;
    logic [31:0] i_imem_rdata;
    logic        o_s2_valid;
    logic        i_s2_busy;
    logic [4:0]  o_s2_rd;
    logic [4:0]  o_s2_rs1;
    logic [4:0]  o_s2_rs2;
    logic [31:0] o_s2_imm;
    logic [31:0] o_s2_pc;
    frv_uop_e    o_s2_uop;
    frv_fu_e     o_s2_fu;
    logic        o_s2_trap;
    logic [31:0] o_s2_instr;

    logic [31:0] mem [0:MEM_WORDS-1];   // Program image
    integer      seed;
    logic [31:0] exp_pc;                // Next pc due at dispatch
    int          delivered;
    int          idle;                  // Cycles since last transfer
    int          cf_wait;               // Cycles the open request has waited
    logic        cf_done;               // Ack seen, drop request next

    frv_clock #(.PERIOD(40)) i_clock (.o_clk(g_clk));

    frv_front #(
        .FRV_PC_RESET_VALUE (MEM_BASE)
    ) i_dut (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .i_cf_req (i_cf_req), .i_cf_target (i_cf_target), .o_cf_ack (o_cf_ack),
        .o_imem_cen (o_imem_cen), .o_imem_addr (o_imem_addr),
        .i_imem_stall (i_imem_stall), .i_imem_error (i_imem_error),
        .i_imem_rdata (i_imem_rdata),
        .o_s2_valid (o_s2_valid), .i_s2_busy (i_s2_busy),
        .o_s2_rd (o_s2_rd), .o_s2_rs1 (o_s2_rs1), .o_s2_rs2 (o_s2_rs2),
        .o_s2_imm (o_s2_imm), .o_s2_pc (o_s2_pc), .o_s2_uop (o_s2_uop),
        .o_s2_fu (o_s2_fu), .o_s2_trap (o_s2_trap), .o_s2_instr (o_s2_instr)
    );

    // Memory model ------------------------------------------------
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - MEM_BASE;
        if (off < 32'h400) begin
            return mem[off[9:2]];
        end
        return addr ^ 32'h5a5a_a5a5;        // Outside the image
    endfunction

    function automatic logic err_at(input logic [31:0] addr);
        return (addr >= ERR_LO) && (addr < ERR_HI);
    endfunction

    // Legal word of a chosen kind, or the raw bits
    function automatic logic [31:0] make_word(input logic [31:0] kind, input logic [31:0] r);
        logic [31:0] w;
        logic [6:0]  f7;
        w = r;
        case (kind % 32'd12)
            0: w[6:0] = OPC_LUI;
            1: w[6:0] = OPC_AUIPC;
            2: w[6:0] = OPC_JAL;
            3: w = {r[31:15], 3'b000, r[11:7], OPC_JALR};
            4: w = {r[31:15], r[14], r[14] & r[13], r[12], r[11:7], OPC_BRANCH};
            5: w = {r[31:15], r[14], ~r[14] & r[13], r[12], r[11:7], OPC_LOAD};
            6: w = {r[31:15], 1'b0, r[13] & ~r[12], r[12], r[11:7], OPC_STORE};
            7: begin
                f7 = (r[13:12] == 2'b01) ? {1'b0, r[30] & r[14], 5'b0} : r[31:25];
                w  = {f7, r[24:7], OPC_OP_IMM};      // Shift amounts stay legal
            end
            8: begin
                f7 = {1'b0, r[30] & (r[14:12] == 3'b000 || r[14:12] == 3'b101), 5'b0};
                w  = {f7, r[24:7], OPC_OP};
            end
            default: ;                                // Mostly unknown opcodes
        endcase
        return w;
    endfunction

    // Reference decoder -------------------------------------------
    function automatic frv_decoded_t ref_decode(input logic [31:0] w, input logic err,
                                                input logic [31:0] pc);
        frv_decoded_t d;
        logic [31:0]  imm_i;
        logic [2:0]   f3;
        logic [6:0]   f7;
        logic         is_op;
        logic         ok;
        imm_i   = $signed(w) >>> 20;
        f3      = w[14:12];
        f7      = w[31:25];
        is_op   = (w[6:0] == OPC_OP);
        ok      = 1'b1;
        d       = '0;
        d.pc    = pc;
        d.instr = w;
        d.rd    = w[11:7];
        d.rs1   = w[19:15];
        d.rs2   = w[24:20];
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: begin
                d.uop = (w[6:0] == OPC_LUI) ? UOP_LUI : UOP_AUIPC;
                d.fu  = FU_ALU;
                d.imm = {w[31:12], 12'h000};
                d.rs1 = 5'd0;
                d.rs2 = 5'd0;
            end
            OPC_JAL: begin
                d.uop = UOP_JAL;
                d.fu  = FU_JUMP;
                d.imm = {imm_i[31:20], w[19:12], w[20], w[30:21], 1'b0};
                d.rs1 = 5'd0;
                d.rs2 = 5'd0;
            end
            OPC_JALR: begin
                d.uop = UOP_JALR;
                d.fu  = FU_JUMP;
                d.imm = imm_i;
                d.rs2 = 5'd0;
                ok    = (f3 == 3'b000);
            end
            OPC_BRANCH: begin
                d.fu  = FU_JUMP;
                d.imm = {imm_i[31:12], w[7], w[30:25], w[11:8], 1'b0};
                d.rd  = 5'd0;
                case (f3)
                    3'b000:  d.uop = UOP_BEQ;
                    3'b001:  d.uop = UOP_BNE;
                    3'b100:  d.uop = UOP_BLT;
                    3'b101:  d.uop = UOP_BGE;
                    3'b110:  d.uop = UOP_BLTU;
                    3'b111:  d.uop = UOP_BGEU;
                    default: ok = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                d.fu  = FU_MEM;
                d.imm = imm_i;
                d.rs2 = 5'd0;
                case (f3)
                    3'b000:  d.uop = UOP_LB;
                    3'b001:  d.uop = UOP_LH;
                    3'b010:  d.uop = UOP_LW;
                    3'b100:  d.uop = UOP_LBU;
                    3'b101:  d.uop = UOP_LHU;
                    default: ok = 1'b0;
                endcase
            end
            OPC_STORE: begin
                d.fu  = FU_MEM;
                d.imm = {imm_i[31:5], w[11:7]};
                d.rd  = 5'd0;
                case (f3)
                    3'b000:  d.uop = UOP_SB;
                    3'b001:  d.uop = UOP_SH;
                    3'b010:  d.uop = UOP_SW;
                    default: ok = 1'b0;
                endcase
            end
            OPC_OP_IMM, OPC_OP: begin
                d.fu  = FU_ALU;
                d.imm = is_op ? 32'd0 : imm_i;
                if (!is_op) begin
                    d.rs2 = 5'd0;                   // Shamt lives in the immediate
                end
                case (f3)
                    3'b000:  d.uop = (is_op && f7[5]) ? UOP_SUB : UOP_ADD;
                    3'b001:  d.uop = UOP_SLL;
                    3'b010:  d.uop = UOP_SLT;
                    3'b011:  d.uop = UOP_SLTU;
                    3'b100:  d.uop = UOP_XOR;
                    3'b101:  d.uop = f7[5] ? UOP_SRA : UOP_SRL;
                    3'b110:  d.uop = UOP_OR;
                    default: d.uop = UOP_AND;
                endcase
                // Register ops and shifts allow only 0x00, or 0x20 on SUB and SRA
                if (is_op || f3[1:0] == 2'b01) begin
                    ok = (f7 == 7'h00) ||
                         (f7 == 7'h20 && (f3 == 3'b101 || (is_op && f3 == 3'b000)));
                end
            end
            default: ok = 1'b0;
        endcase
        if (err || !ok) begin
            d       = '0;
            d.pc    = pc;
            d.instr = w;
            d.uop   = UOP_NOP;
            d.fu    = FU_TRAP;
            d.trap  = 1'b1;
        end
        return d;
    endfunction

    // Checks ------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at time %0t: pc %h expected %h",
                                     $time, got, exp));
        end
    endtask

    task automatic check_decoded(input frv_decoded_t got, input frv_decoded_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at time %0t: pc %h uop %s/%s got %h expected %h",
                                     $time, exp.pc, got.uop.name(), exp.uop.name(), got, exp));
        end
    endtask

    // Stimulus on the falling edge --------------------------------
    task automatic drive_inputs();
        logic [31:0] rnd;
        rnd          = $random(seed);
        i_imem_stall = (rnd[1:0] == 2'b00);         // About one in four
        rnd          = $random(seed);
        i_s2_busy    = (rnd[1:0] == 2'b00);
        rnd          = $random(seed);
        if (cf_done) begin
            i_cf_req = 1'b0;
            cf_done  = 1'b0;
        end else if (!i_cf_req && rnd[4:0] == 5'd0) begin
            rnd         = $random(seed);
            i_cf_req    = 1'b1;                     // Held until acked
            i_cf_target = MEM_BASE + {22'd0, rnd[7:0], 2'b00};
        end
        i_imem_rdata = mem_word(o_imem_addr);
        i_imem_error = err_at(o_imem_addr);
    endtask

    // Handshakes that complete at the coming rising edge
    task automatic sample_edge();
        frv_decoded_t got;
        if (o_s2_valid && !i_s2_busy) begin
            check_pc(o_s2_pc, exp_pc);
            got.rd    = o_s2_rd;
            got.rs1   = o_s2_rs1;
            got.rs2   = o_s2_rs2;
            got.imm   = o_s2_imm;
            got.pc    = o_s2_pc;
            got.uop   = o_s2_uop;
            got.fu    = o_s2_fu;
            got.trap  = o_s2_trap;
            got.instr = o_s2_instr;
            check_decoded(got, ref_decode(mem_word(exp_pc), err_at(exp_pc), exp_pc));
            exp_pc    = exp_pc + 32'd4;
            delivered = delivered + 1;
            idle      = 0;
        end else begin
            idle = idle + 1;
            if (idle > IDLE_LIMIT) begin
                report_failure($sformatf("Timeout: no instruction delivered for %0d cycles",
                                         IDLE_LIMIT));
            end
        end
        if (o_cf_ack) begin
            exp_pc  = i_cf_target;                  // After any transfer this edge
            cf_done = 1'b1;
            cf_wait = 0;
        end else if (i_cf_req) begin
            cf_wait = cf_wait + 1;
            if (cf_wait > CF_LIMIT) begin
                report_failure("Timeout: control flow request was never acknowledged");
            end
        end
    endtask

    // Main sequence -----------------------------------------------
    initial begin
        logic [31:0] kind_r;
        logic [31:0] bits_r;
        seed         = 32;
        g_resetn     = 1'b0;
        i_cf_req     = 1'b0;
        i_cf_target  = MEM_BASE;
        i_imem_stall = 1'b0;
        i_imem_error = 1'b0;
        i_imem_rdata = 32'd0;
        i_s2_busy    = 1'b0;
        exp_pc       = MEM_BASE;
        delivered    = 0;
        idle         = 0;
        cf_wait      = 0;
        cf_done      = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            kind_r = $random(seed);
            bits_r = $random(seed);
            mem[i] = make_word(kind_r, bits_r);
        end
        repeat (16) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        while (delivered < N_DELIVER) begin
            drive_inputs();
            #(SETTLE);                              // Outputs settled, edge still ahead
            sample_edge();
            @(posedge g_clk);
            @(negedge g_clk);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* test/frv_front_asserts.sv */
/*
 * Protocol assertions for the front end.
 * Memory request hold, output hold under back-pressure, ack rules
 * and the state right after reset.
 */
`default_nettype none

module frv_front_asserts (
    input  logic         g_clk,
    input  logic         g_resetn,
    input  logic         i_imem_cen,
    input  logic [31:0]  i_imem_addr,
    input  logic         i_imem_stall,
    input  logic         i_cf_req,
    input  logic [31:0]  i_cf_target,
    input  logic         i_cf_ack,
    input  logic         i_s2_valid,
    input  logic         i_s2_busy,
    input  logic [118:0] i_s2_out        // All o_s2_* fields packed
);

    // Stalled request keeps its address
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_imem_cen && i_imem_stall |=> i_imem_cen && $stable(i_imem_addr))
        else $error("imem request dropped or moved during stall");

    // Held output unless a redirect flushes it
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_s2_valid && i_s2_busy && !i_cf_ack |=> i_s2_valid && $stable(i_s2_out))
        else $error("s2 outputs changed while dispatch was busy");

    // Ack only with a request, next fetch address is the target
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_cf_ack |=> $past(i_cf_req) && (i_imem_addr == $past(i_cf_target)))
        else $error("control flow ack without a request or fetch not redirected");

    // Quiet front end out of reset
    assert property (@(posedge g_clk)
        !g_resetn |=> !i_s2_valid && !i_imem_cen)
        else $error("valid or memory request right after reset");

endmodule

bind frv_front frv_front_asserts i_asserts (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_imem_cen   (o_imem_cen),
    .i_imem_addr  (o_imem_addr),
    .i_imem_stall (i_imem_stall),
    .i_cf_req     (i_cf_req),
    .i_cf_target  (i_cf_target),
    .i_cf_ack     (o_cf_ack),
    .i_s2_valid   (o_s2_valid),
    .i_s2_busy    (i_s2_busy),
    .i_s2_out     ({o_s2_rd, o_s2_rs1, o_s2_rs2, o_s2_imm, o_s2_pc,
                    o_s2_uop, o_s2_fu, o_s2_trap, o_s2_instr})
);

`default_nettype wire

/* test/frv_clock.sv */
/*
 * Testbench clock source.
 */
`default_nettype none

module frv_clock #(
    parameter int PERIOD = 40               // Full clock period
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;   // Half period per phase
    end

endmodule

`default_nettype wire

/* logic/frv_front.sv */
/*
 * RV32I pipeline front end.
 * Fetch, decode and the output register toward dispatch, with
 * redirect on control flow change.
 */
`default_nettype none

module frv_front #(
    parameter logic [31:0] FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic               g_clk,
    input  logic               g_resetn,

    input  logic               i_cf_req,        // Control flow change request
    input  logic [31:0]        i_cf_target,     // Change destination
    output logic               o_cf_ack,        // Change acknowledge

    output logic               o_imem_cen,      // Memory read request
    output logic [31:0]        o_imem_addr,     // Read address
    input  logic               i_imem_stall,    // Memory stall
    input  logic               i_imem_error,    // Read fault
    input  logic [31:0]        i_imem_rdata,    // Read data

    output logic               o_s2_valid,      // Decoded instruction ready
    input  logic               i_s2_busy,       // Dispatch not taking
    output logic [4:0]         o_s2_rd,
    output logic [4:0]         o_s2_rs1,
    output logic [4:0]         o_s2_rs2,
    output logic [31:0]        o_s2_imm,
    output logic [31:0]        o_s2_pc,
    output frv_pkg::frv_uop_e  o_s2_uop,
    output frv_pkg::frv_fu_e   o_s2_fu,
    output logic               o_s2_trap,
    output logic [31:0]        o_s2_instr
);
    import frv_pkg::*;

    frv_fetch_if  fetch_bus ();     // Fetch buffer to decode

    logic         fe_stall;         // Pipe register full and held
    frv_decoded_t dec_data;         // Decoder output
    frv_decoded_t s2_data;          // Registered toward dispatch

    // Stages -------------------------------------------------------
    frv_fetch #(
        .FRV_PC_RESET_VALUE (FRV_PC_RESET_VALUE)
    ) i_fetch (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .i_cf_req     (i_cf_req),
        .i_cf_target  (i_cf_target),
        .o_cf_ack     (o_cf_ack),
        .o_imem_cen   (o_imem_cen),
        .o_imem_addr  (o_imem_addr),
        .i_imem_stall (i_imem_stall),
        .i_imem_error (i_imem_error),
        .i_imem_rdata (i_imem_rdata),
        .i_stall      (fe_stall),
        .o_fetch      (fetch_bus.fetch)
    );

    frv_decode i_decode (
        .i_fetch   (fetch_bus.decode),
        .o_decoded (dec_data)
    );

    frv_pipe_reg i_pipe_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (o_cf_ack),       // Redirect flushes the entry
        .i_valid  (fetch_bus.valid),
        .i_data   (dec_data),
        .o_busy   (fe_stall),
        .o_valid  (o_s2_valid),
        .o_data   (s2_data),
        .i_busy   (i_s2_busy)
    );

    // Unpack toward dispatch
    assign o_s2_rd    = s2_data.rd;
    assign o_s2_rs1   = s2_data.rs1;
    assign o_s2_rs2   = s2_data.rs2;
    assign o_s2_imm   = s2_data.imm;
    assign o_s2_pc    = s2_data.pc;
    assign o_s2_uop   = s2_data.uop;
    assign o_s2_fu    = s2_data.fu;
    assign o_s2_trap  = s2_data.trap;
    assign o_s2_instr = s2_data.instr;

endmodule

`default_nettype wire

/* logic/frv_pipe_reg.sv */
/*
 * Single entry pipeline register with valid/busy handshake and flush.
 */
`default_nettype none

module frv_pipe_reg (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_flush,      // Drop the held entry
    input  logic                  i_valid,      // Upstream has data
    input  frv_pkg::frv_decoded_t i_data,       // Upstream data
    output logic                  o_busy,       // Upstream must hold
    output logic                  o_valid,      // Entry held
    output frv_pkg::frv_decoded_t o_data,       // Entry to next stage
    input  logic                  i_busy        // Next stage not taking
);

    logic                  valid_q;
    frv_pkg::frv_decoded_t data_q;
    logic                  load;                // Capture at this edge

    assign o_busy = valid_q && i_busy;          // Full and not draining
    assign load   = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;                    // Redirect clears entry
        end else if (!o_busy) begin
            valid_q <= i_valid;                 // Refill or go empty
        end
    end

    always_ff @(posedge g_clk) begin
        if (load) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

`default_nettype wire

/* logic/frv_decode.sv */
/*
 * RV32I decoder.
 * Turns a fetched word into micro-op, functional unit, register fields
 * and immediate. Unknown encodings and faulted fetches become traps.
 */
`default_nettype none

module frv_decode (
    frv_fetch_if.decode           i_fetch,      // Word from the fetch buffer
    output frv_pkg::frv_decoded_t o_decoded     // Wide pipeline encoding
);
    import frv_pkg::*;

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    frv_uop_e    uop;
    frv_fu_e     fu;
    logic        known;         // Legal encoding
    logic        use_rd;
    logic        use_rs1;
    logic        use_rs2;
    logic [31:0] imm;
    logic        trap;

    assign instr  = i_fetch.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Immediate formats --------------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Opcode and funct decode --------------------------------------
    always_comb begin
        uop     = UOP_NOP;
        fu      = FU_TRAP;
        known   = 1'b1;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        imm     = 32'd0;
        case (opcode)
            OPC_LUI: begin
                uop = UOP_LUI;   fu = FU_ALU;  use_rd = 1'b1;  imm = imm_u;
            end
            OPC_AUIPC: begin
                uop = UOP_AUIPC; fu = FU_ALU;  use_rd = 1'b1;  imm = imm_u;
            end
            OPC_JAL: begin
                uop = UOP_JAL;   fu = FU_JUMP; use_rd = 1'b1;  imm = imm_j;
            end
            OPC_JALR: begin
                uop = UOP_JALR;  fu = FU_JUMP; use_rd = 1'b1;  use_rs1 = 1'b1;
                imm = imm_i;
                known = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                fu = FU_JUMP;  use_rs1 = 1'b1;  use_rs2 = 1'b1;  imm = imm_b;
                case (funct3)
                    3'b000:  uop = UOP_BEQ;
                    3'b001:  uop = UOP_BNE;
                    3'b100:  uop = UOP_BLT;
                    3'b101:  uop = UOP_BGE;
                    3'b110:  uop = UOP_BLTU;
                    3'b111:  uop = UOP_BGEU;
                    default: known = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                fu = FU_MEM;  use_rd = 1'b1;  use_rs1 = 1'b1;  imm = imm_i;
                case (funct3)
                    3'b000:  uop = UOP_LB;
                    3'b001:  uop = UOP_LH;
                    3'b010:  uop = UOP_LW;
                    3'b100:  uop = UOP_LBU;
                    3'b101:  uop = UOP_LHU;
                    default: known = 1'b0;
                endcase
            end
            OPC_STORE: begin
                fu = FU_MEM;  use_rs1 = 1'b1;  use_rs2 = 1'b1;  imm = imm_s;
                case (funct3)
                    3'b000:  uop = UOP_SB;
                    3'b001:  uop = UOP_SH;
                    3'b010:  uop = UOP_SW;
                    default: known = 1'b0;
                endcase
            end
            OPC_OP_IMM, OPC_OP: begin
                fu = FU_ALU;  use_rd = 1'b1;  use_rs1 = 1'b1;
                use_rs2 = (opcode == OPC_OP);
                imm     = (opcode == OPC_OP) ? 32'd0 : imm_i;
                case (funct3)
                    3'b000: begin
                        if (opcode == OPC_OP && funct7[5]) begin
                            uop = UOP_SUB;
                        end else begin
                            uop = UOP_ADD;
                        end
                    end
                    3'b001:  uop = UOP_SLL;
                    3'b010:  uop = UOP_SLT;
                    3'b011:  uop = UOP_SLTU;
                    3'b100:  uop = UOP_XOR;
                    3'b101: begin
                        if (funct7[5]) begin
                            uop = UOP_SRA;
                        end else begin
                            uop = UOP_SRL;
                        end
                    end
                    3'b110:  uop = UOP_OR;
                    default: uop = UOP_AND;
                endcase
                // funct7 only free for OP-IMM non-shifts; bit 5 only on SUB/SRA/SRAI
                if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101) begin
                    known = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && funct3 == 3'b101) ||
                            (funct7 == 7'b0100000 && funct3 == 3'b000 && opcode == OPC_OP);
                end
            end
            default: known = 1'b0;
        endcase
    end

    assign trap = !known || i_fetch.error;                  // Fault wins over decode

    // Output record, zeroed fields on trap
    always_comb begin
        o_decoded.rd    = (use_rd && !trap)  ? instr[11:7]  : 5'd0;
        o_decoded.rs1   = (use_rs1 && !trap) ? instr[19:15] : 5'd0;
        o_decoded.rs2   = (use_rs2 && !trap) ? instr[24:20] : 5'd0;
        o_decoded.imm   = trap ? 32'd0 : imm;
        o_decoded.pc    = i_fetch.pc;
        o_decoded.uop   = trap ? UOP_NOP : uop;
        o_decoded.fu    = trap ? FU_TRAP : fu;
        o_decoded.trap  = trap;
        o_decoded.instr = instr;
    end

endmodule

`default_nettype wire

/* logic/frv_fetch.sv */
/*
 * Fetch stage.
 * Keeps the fetch PC, requests words from instruction memory, holds
 * one response in a buffer and takes control flow changes.
 */
`default_nettype none

module frv_fetch #(
    parameter logic [31:0] FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        i_cf_req,       // Control flow change request
    input  logic [31:0] i_cf_target,    // New PC
    output logic        o_cf_ack,       // Change taken this cycle
    output logic        o_imem_cen,     // Read request
    output logic [31:0] o_imem_addr,    // Read address
    input  logic        i_imem_stall,   // Memory not ready
    input  logic        i_imem_error,   // Response faulted
    input  logic [31:0] i_imem_rdata,   // Response word
    input  logic        i_stall,        // Pipe register busy
    frv_fetch_if.fetch  o_fetch         // Buffered word to decode
);

    logic        run_q;         // Out of reset
    logic        hold_q;        // Stalled request must stay up
    logic [31:0] pc_q;          // Next fetch address
    logic        buf_valid_q;
    logic [31:0] buf_instr_q;
    logic        buf_error_q;
    logic [31:0] buf_pc_q;

    logic        buf_free;      // Buffer can take a word at the edge
    logic        mem_accept;    // Request accepted this cycle
    logic        cf_change;     // Redirect at this edge

    // Request control ----------------------------------------------
    assign buf_free    = !buf_valid_q || !i_stall;          // Empty or draining
    assign o_imem_cen  = run_q && (hold_q || (buf_free && !i_cf_req));
    assign o_imem_addr = pc_q;                              // Stable while stalled
    assign mem_accept  = o_imem_cen && !i_imem_stall;

    // No ack while a stalled read is still up
    assign o_cf_ack  = i_cf_req && !(o_imem_cen && i_imem_stall);
    assign cf_change = o_cf_ack;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            run_q       <= 1'b0;
            hold_q      <= 1'b0;
            buf_valid_q <= 1'b0;
            pc_q        <= FRV_PC_RESET_VALUE;
        end else begin
            run_q  <= 1'b1;
            hold_q <= o_imem_cen && i_imem_stall;           // Keep cen up next cycle
            if (cf_change) begin
                pc_q        <= i_cf_target;                 // Redirect, drop buffer
                buf_valid_q <= 1'b0;
            end else if (mem_accept) begin
                pc_q        <= pc_q + 32'd4;
                buf_valid_q <= 1'b1;
            end else if (buf_valid_q && !i_stall) begin
                buf_valid_q <= 1'b0;                        // Moved on, nothing new
            end
        end
    end

    // Response capture
    always_ff @(posedge g_clk) begin
        if (mem_accept) begin
            buf_instr_q <= i_imem_rdata;
            buf_error_q <= i_imem_error;
            buf_pc_q    <= pc_q;                            // PC of this word
        end
    end

    assign o_fetch.valid = buf_valid_q;
    assign o_fetch.instr = buf_instr_q;
    assign o_fetch.error = buf_error_q;
    assign o_fetch.pc    = buf_pc_q;

endmodule

`default_nettype wire

/* logic/frv_fetch_if.sv */
/*
 * Fetched word from the fetch buffer to the decoder.
 */
`default_nettype none

interface frv_fetch_if;

    logic        valid;     // Buffer holds a word
    logic [31:0] instr;     // Fetched word
    logic        error;     // Word came back with a memory error
    logic [31:0] pc;        // Address the word was read from

    modport fetch (output valid, output instr, output error, output pc);

    modport decode (input valid, input instr, input error, input pc);

endinterface

`default_nettype wire

/* logic/frv_pkg.sv */
/*
 * RV32I front end shared types.
 * Micro-op and functional unit encodings, decoded instruction layout,
 * and major opcode values.
 */
`default_nettype none

package frv_pkg;

    // Micro-ops ----------------------------------------------------
    typedef enum logic [4:0] {
        UOP_LUI,   UOP_AUIPC, UOP_JAL,  UOP_JALR,            // Upper imm and jumps
        UOP_BEQ,   UOP_BNE,   UOP_BLT,  UOP_BGE,             // Branches
        UOP_BLTU,  UOP_BGEU,
        UOP_LB,    UOP_LH,    UOP_LW,   UOP_LBU,   UOP_LHU,  // Loads
        UOP_SB,    UOP_SH,    UOP_SW,                        // Stores
        UOP_ADD,   UOP_SUB,   UOP_SLL,  UOP_SLT,   UOP_SLTU, // Arithmetic
        UOP_XOR,   UOP_SRL,   UOP_SRA,  UOP_OR,    UOP_AND,
        UOP_NOP                                              // Trapped word
    } frv_uop_e;

    typedef enum logic [1:0] {
        FU_ALU,                 // Arithmetic and upper immediates
        FU_MEM,                 // Loads and stores
        FU_JUMP,                // Jumps and branches
        FU_TRAP                 // Illegal or faulted fetch
    } frv_fu_e;

    // Decoded instruction, 119 bits --------------------------------
    typedef struct packed {
        logic [4:0]  rd;        // Destination register
        logic [4:0]  rs1;       // Source register 1
        logic [4:0]  rs2;       // Source register 2
        logic [31:0] imm;       // Sign extended immediate
        logic [31:0] pc;        // Address of the word
        frv_uop_e    uop;       // Micro-op
        frv_fu_e     fu;        // Functional unit
        logic        trap;      // Raise a trap
        logic [31:0] instr;     // Raw instruction word
    } frv_decoded_t;

    // Major opcodes ------------------------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

`default_nettype wire
